//--- verilog.f
hdl/pipe_pkg.sv
hdl/pipe_stage_reg.sv
hdl/int_decoder.sv
hdl/reg_file.sv
hdl/int_alu.sv
hdl/hazard_ctrl.sv
hdl/int_pipe_top.sv
tb/int_pipe_properties.sv
tb/int_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the pipeline testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module int_pipe_tb -f verilog.f \
    || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vint_pipe_tb)"
echo "$sim_out"
echo "$sim_out" | grep -qx "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb/int_pipe_tb.sv
// testbench for the integer pipeline
//   stimulus table with expected retire values from a reference register model
//   valid/ready driver, retire monitor, compare tasks, watchdog
`timescale 1ns/1ps

module int_pipe_tb;
    import pipe_pkg::*;

    localparam int MAX_ROWS = 32;

    typedef struct packed {
        instr_t     instr;
        xlen_t      pc;
        logic [3:0] gap;
        logic       consec;
        reg_idx_t   exp_rd;
        logic       exp_wen;
        xlen_t      exp_wdata;
    } row_t;

    logic     clk;
    logic     arst_n_i;
    logic     in_valid_i;
    xlen_t    in_pc_i;
    instr_t   in_instr_i;
    logic     in_ready_o;
    logic     retire_valid_o;
    xlen_t    retire_pc_o;
    reg_idx_t retire_rd_o;
    xlen_t    retire_wdata_o;
    logic     retire_wen_o;
    logic     halted_o;

    row_t rows [MAX_ROWS];
    int   n_rows = 0;
    int   n_expected = 0;
    int   errors = 0;
    int   retired = 0;
    int   exp_q [$];

    int_pipe_top int_pipe_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // funct is {funct7, funct3}
    function automatic instr_t op_instr(input logic [9:0] funct, input reg_idx_t rd,
                                        input reg_idx_t rs1, input reg_idx_t rs2);
        return {funct[9:3], rs2, rs1, funct[2:0], rd, OPC_OP};
    endfunction

    function automatic instr_t addi_instr(input reg_idx_t rd, input reg_idx_t rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t lui_instr(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic add_row(input instr_t ins, input int gap, input logic consec);
        rows[n_rows]        = '0;
        rows[n_rows].instr  = ins;
        rows[n_rows].pc     = 64'h8000_0000 + 64'(4 * n_rows);
        rows[n_rows].gap    = 4'(gap);
        rows[n_rows].consec = consec;
        n_rows++;
    endtask

    task automatic build_table();
        // independent ops with producers at least three slots ahead
        add_row(addi_instr(5'd1, 5'd0, 12'($urandom())), 0, 1'b0);
        add_row(lui_instr(5'd2, 20'($urandom())), 0, 1'b1);
        add_row(addi_instr(5'd3, 5'd0, 12'($urandom())), 0, 1'b1);
        add_row(addi_instr(5'd4, 5'd0, 12'($urandom())), 0, 1'b1);
        add_row(op_instr(10'h000, 5'd5, 5'd1, 5'd2), 0, 1'b1);
        add_row(op_instr(10'h004, 5'd6, 5'd1, 5'd3), 0, 1'b1);
        // back-to-back raw chain
        add_row(addi_instr(5'd7, 5'd0, 12'($urandom())), 0, 1'b0);
        add_row(op_instr(10'h000, 5'd8, 5'd7, 5'd5), 0, 1'b0);
        add_row(op_instr(10'h100, 5'd9, 5'd8, 5'd7), 0, 1'b0);
        // random operands through sub, and, or, xor
        add_row(addi_instr(5'd10, 5'd0, 12'($urandom())), 2, 1'b0);
        add_row(lui_instr(5'd11, 20'($urandom())), 0, 1'b0);
        add_row(op_instr(10'h100, 5'd12, 5'd10, 5'd11), 0, 1'b0);
        add_row(op_instr(10'h007, 5'd13, 5'd10, 5'd11), 0, 1'b0);
        add_row(op_instr(10'h006, 5'd14, 5'd11, 5'd10), 0, 1'b0);
        add_row(op_instr(10'h004, 5'd15, 5'd10, 5'd11), 0, 1'b0);
        // x0 as destination, then as source
        add_row(addi_instr(5'd0, 5'd1, 12'($urandom())), 1, 1'b0);
        add_row(op_instr(10'h000, 5'd16, 5'd0, 5'd6), 0, 1'b0);
        // custom-0 opcode aimed at x17, then read x17
        add_row(32'h0000_088B, 0, 1'b0);
        add_row(addi_instr(5'd18, 5'd17, 12'h001), 0, 1'b0);
        // ebreak and the instructions that must never retire
        add_row(INSTR_EBREAK, 1, 1'b0);
        add_row(addi_instr(5'd20, 5'd0, 12'h0aa), 0, 1'b0);
        add_row(addi_instr(5'd21, 5'd0, 12'h0bb), 0, 1'b0);
        add_row(addi_instr(5'd22, 5'd0, 12'h0cc), 0, 1'b0);
        add_row(lui_instr(5'd23, 20'h12345), 0, 1'b0);
    endtask

    // rv64 semantics in program order
    task automatic run_model();
        xlen_t  ref_regs [NUM_REGS];
        logic   halt_seen;
        instr_t ins;
        xlen_t  a;
        xlen_t  b;
        xlen_t  res;
        logic   wr;
        halt_seen = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < n_rows; i++) begin
            ins = rows[i].instr;
            a   = ref_regs[ins[19:15]];
            b   = ref_regs[ins[24:20]];
            wr  = 1'b0;
            res = '0;
            case (ins[6:0])
                OPC_OP: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h004: res = a ^ b;
                        10'h006: res = a | b;
                        10'h007: res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                OPC_OP_IMM: begin
                    wr  = (ins[14:12] == 3'b000);
                    res = a + {{52{ins[31]}}, ins[31:20]};
                end
                OPC_LUI: begin
                    wr  = 1'b1;
                    res = {{32{ins[31]}}, ins[31:12], 12'h000};
                end
                default: ;
            endcase
            wr = wr && (ins[11:7] != 5'd0) && !halt_seen;
            rows[i].exp_rd     = ins[11:7];
            rows[i].exp_wen    = wr;
            rows[i].exp_wdata  = res;
            if (wr) begin
                ref_regs[ins[11:7]] = res;
            end
            if (!halt_seen) begin
                exp_q.push_back(i);
            end
            if (ins == INSTR_EBREAK) begin
                halt_seen = 1'b1;
            end
        end
        n_expected = exp_q.size();
    endtask

    task automatic drive_rows();
        logic accepted;
        logic blocked;
        blocked = 1'b0;
        for (int i = 0; i < n_rows && !blocked; i++) begin
            in_valid_i = 1'b0;
            repeat (rows[i].gap) begin
                @(posedge clk);
                #1;
            end
            in_valid_i = 1'b1;
            in_pc_i    = rows[i].pc;
            in_instr_i = rows[i].instr;
            accepted   = 1'b0;
            while (!accepted && !blocked) begin
                @(negedge clk);
                accepted = in_ready_o;
                blocked  = halted_o;
                @(posedge clk);
                #1;
            end
        end
        // a refused instruction stays offered while halted
        if (!blocked) begin
            in_valid_i = 1'b0;
        end
    endtask

    task automatic watch_retires();
        int cyc;
        int last_retire;
        int idx;
        int errs_before;
        cyc         = 0;
        last_retire = -10;
        forever begin
            @(negedge clk);
            cyc++;
            if (retire_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected retire of pc %h at %0d ns, nothing was left to retire",
                             retire_pc_o, $time);
                    errors++;
                end else begin
                    idx         = exp_q.pop_front();
                    errs_before = errors;
                    check_xlen("retire_pc_o", retire_pc_o, rows[idx].pc);
                    check_reg_idx("retire_rd_o", retire_rd_o, rows[idx].exp_rd);
                    check_bit("retire_wen_o", retire_wen_o, rows[idx].exp_wen);
                    if (rows[idx].exp_wen) begin
                        check_xlen("retire_wdata_o", retire_wdata_o, rows[idx].exp_wdata);
                    end
                    if (rows[idx].consec) begin
                        check_bit("back-to-back retire", cyc == last_retire + 1, 1'b1);
                    end
                    check_bit("halted_o at retire", halted_o, 1'b0);
                    $display("test %0d pc %h: %s", idx, rows[idx].pc,
                             (errors == errs_before) ? "ok" : "FAILED");
                end
                retired++;
                last_retire = cyc;
            end
        end
    endtask

    initial begin
        int errs_before;
        void'($urandom(32'h7bc69cea));
        arst_n_i   = 1'b0;
        in_valid_i = 1'b0;
        in_pc_i    = '0;
        in_instr_i = '0;
        build_table();
        run_model();
        repeat (4) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check_bit("in_ready_o after reset", in_ready_o, 1'b1);
        check_bit("halted_o after reset", halted_o, 1'b0);
        check_bit("retire_valid_o after reset", retire_valid_o, 1'b0);
        fork
            watch_retires();
        join_none
        drive_rows();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // give flushed instructions time to show up if they leaked
        repeat (10) @(posedge clk);
        #1;
        errs_before = errors;
        check_bit("halted_o after ebreak", halted_o, 1'b1);
        check_bit("in_ready_o while halted", in_ready_o, 1'b0);
        check_bit("retired count matches issued", retired == n_expected, 1'b1);
        $display("halt test: %s", (errors == errs_before) ? "ok" : "FAILED");
        $display("rows %0d, retired %0d of %0d, errors %0d", n_rows, retired, n_expected, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (n_rows * 4 + 200) @(posedge clk);
        $display("timeout: the run did not complete within %0d cycles", n_rows * 4 + 200);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tb/int_pipe_properties.sv
// concurrent checks bound to the pipeline top level
//   input refused once halted
//   nothing retires once halted
//   a writing retire never targets x0
`timescale 1ns/1ps

module int_pipe_properties (
    input logic               clk,
    input logic               arst_n_i,
    input logic               in_ready_o,
    input logic               retire_valid_o,
    input pipe_pkg::reg_idx_t retire_rd_o,
    input logic               retire_wen_o,
    input logic               halted_o
);

    halt_blocks_input: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_o |-> !in_ready_o)
        else $error("in_ready_o is high while the core is halted");

    // halted stays high until reset, so this covers every later cycle
    no_retire_when_halted: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_o |-> !retire_valid_o)
        else $error("an instruction retired after the core halted");

    wen_needs_rd: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_wen_o |-> (retire_rd_o != '0))
        else $error("retire_wen_o is high with x0 as destination");

endmodule

bind int_pipe_top int_pipe_properties int_pipe_properties_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .in_ready_o     (in_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_wen_o   (retire_wen_o),
    .halted_o       (halted_o)
);

//--- hdl/int_pipe_top.sv
// three stage rv64 integer pipeline
//   decode, execute and writeback stage registers
//   decoder, register file, alu and hazard control
//   valid/ready instruction input, retire observation port
`timescale 1ns/1ps

module int_pipe_top (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               in_valid_i,
    input  pipe_pkg::xlen_t    in_pc_i,
    input  pipe_pkg::instr_t   in_instr_i,
    output logic               in_ready_o,
    output logic               retire_valid_o,
    output pipe_pkg::xlen_t    retire_pc_o,
    output pipe_pkg::reg_idx_t retire_rd_o,
    output pipe_pkg::xlen_t    retire_wdata_o,
    output logic               retire_wen_o,
    output logic               halted_o
);
    import pipe_pkg::*;

    id_payload_t id_in;
    id_payload_t id_q;
    logic        id_valid;
    ex_payload_t ex_d;
    ex_payload_t ex_q;
    logic        ex_valid;
    wb_payload_t wb_d;
    wb_payload_t wb_q;
    logic        wb_valid;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    logic     use_rs1;
    logic     use_rs2;
    xlen_t    rs1_val;
    xlen_t    rs2_val;

    logic stall;
    logic flush;
    logic halted;

    // no new input while stalled, halting or halted
    assign in_ready_o = !stall && !flush && !halted;

    assign id_in.pc    = in_pc_i;
    assign id_in.instr = in_instr_i;

    pipe_stage_reg #(.payload_t(id_payload_t)) id_stage_reg_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush),
        .enable_i (!stall),
        .valid_i  (in_valid_i && in_ready_o),
        .data_i   (id_in),
        .valid_o  (id_valid),
        .data_o   (id_q)
    );

    int_decoder int_decoder_inst (
        .id_i      (id_q),
        .rs1_o     (rs1_idx),
        .rs2_o     (rs2_idx),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .ex_o      (ex_d)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ra1_i    (rs1_idx),
        .ra2_i    (rs2_idx),
        .rd1_o    (rs1_val),
        .rd2_o    (rs2_val),
        .we_i     (wb_valid && wb_q.wen),
        .wa_i     (wb_q.rd),
        .wd_i     (wb_q.wdata)
    );

    hazard_ctrl hazard_ctrl_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .id_valid_i  (id_valid),
        .rs1_i       (rs1_idx),
        .rs2_i       (rs2_idx),
        .use_rs1_i   (use_rs1),
        .use_rs2_i   (use_rs2),
        .ex_valid_i  (ex_valid),
        .ex_wen_i    (ex_q.wen),
        .ex_rd_i     (ex_q.rd),
        .wb_valid_i  (wb_valid),
        .wb_wen_i    (wb_q.wen),
        .wb_ebreak_i (wb_q.ebreak),
        .wb_rd_i     (wb_q.rd),
        .stall_o     (stall),
        .flush_o     (flush),
        .halted_o    (halted)
    );

    // bubble into execute while decode waits
    pipe_stage_reg #(.payload_t(ex_payload_t)) ex_stage_reg_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush),
        .enable_i (1'b1),
        .valid_i  (id_valid && !stall),
        .data_i   (ex_d),
        .valid_o  (ex_valid),
        .data_o   (ex_q)
    );

    int_alu int_alu_inst (
        .ex_i (ex_q),
        .wb_o (wb_d)
    );

    // flushed as well, so the instruction behind ebreak never retires
    pipe_stage_reg #(.payload_t(wb_payload_t)) wb_stage_reg_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush),
        .enable_i (1'b1),
        .valid_i  (ex_valid),
        .data_i   (wb_d),
        .valid_o  (wb_valid),
        .data_o   (wb_q)
    );

    assign retire_valid_o = wb_valid;
    assign retire_pc_o    = wb_q.pc;
    assign retire_rd_o    = wb_q.rd;
    assign retire_wdata_o = wb_q.wdata;
    assign retire_wen_o   = wb_valid && wb_q.wen;
    assign halted_o       = halted;

endmodule

//--- hdl/hazard_ctrl.sv
// pipeline control
//   read-after-write interlock against execute and writeback
//   halt state machine entered on ebreak in writeback
//   flush of the stage registers on halt entry
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               id_valid_i,
    input  pipe_pkg::reg_idx_t rs1_i,
    input  pipe_pkg::reg_idx_t rs2_i,
    input  logic               use_rs1_i,
    input  logic               use_rs2_i,
    input  logic               ex_valid_i,
    input  logic               ex_wen_i,
    input  pipe_pkg::reg_idx_t ex_rd_i,
    input  logic               wb_valid_i,
    input  logic               wb_wen_i,
    input  logic               wb_ebreak_i,
    input  pipe_pkg::reg_idx_t wb_rd_i,
    output logic               stall_o,
    output logic               flush_o,
    output logic               halted_o
);

    typedef enum logic {
        RUN,
        HALTED
    } halt_state_e;

    halt_state_e state_q;
    logic        ex_writes;
    logic        wb_writes;
    logic        rs1_hit;
    logic        rs2_hit;

    assign ex_writes = ex_valid_i && ex_wen_i;
    assign wb_writes = wb_valid_i && wb_wen_i;

    // x0 never produces a hazard
    assign rs1_hit = use_rs1_i && (rs1_i != '0) &&
                     ((ex_writes && (ex_rd_i == rs1_i)) || (wb_writes && (wb_rd_i == rs1_i)));
    assign rs2_hit = use_rs2_i && (rs2_i != '0) &&
                     ((ex_writes && (ex_rd_i == rs2_i)) || (wb_writes && (wb_rd_i == rs2_i)));

    assign stall_o = id_valid_i && (rs1_hit || rs2_hit);
    assign flush_o = wb_valid_i && wb_ebreak_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RUN;
        end else if (flush_o) begin
            // left only through reset
            state_q <= HALTED;
        end
    end

    assign halted_o = (state_q == HALTED);

endmodule

//--- hdl/int_alu.sv
// execute stage alu
//   second operand is rs2 or the immediate
//   add, sub, and, or, xor and pass-through of operand b
//   builds the writeback payload
`timescale 1ns/1ps

module int_alu (
    input  pipe_pkg::ex_payload_t ex_i,
    output pipe_pkg::wb_payload_t wb_o
);
    import pipe_pkg::*;

    xlen_t op_a;
    xlen_t op_b;
    xlen_t result;

    assign op_a = ex_i.rs1_val;
    assign op_b = ex_i.use_imm ? ex_i.imm : ex_i.rs2_val;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        wb_o.pc     = ex_i.pc;
        wb_o.rd     = ex_i.rd;
        wb_o.wdata  = result;
        wb_o.wen    = ex_i.wen;
        wb_o.ebreak = ex_i.ebreak;
    end

endmodule

//--- hdl/reg_file.sv
// integer register file
//   32 x 64-bit entries, two combinational reads, one write port
//   x0 reads as zero and ignores writes
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n_i,
    input  pipe_pkg::reg_idx_t ra1_i,
    input  pipe_pkg::reg_idx_t ra2_i,
    output pipe_pkg::xlen_t    rd1_o,
    output pipe_pkg::xlen_t    rd2_o,
    input  logic               we_i,
    input  pipe_pkg::reg_idx_t wa_i,
    input  pipe_pkg::xlen_t    wd_i
);
    import pipe_pkg::*;

    xlen_t regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs_q[wa_i] <= wd_i;
        end
    end

    // reads return the value stored before this cycle's write
    assign rd1_o = (ra1_i == '0) ? '0 : regs_q[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs_q[ra2_i];

endmodule

//--- hdl/int_decoder.sv
// instruction decoder for the integer pipeline
//   field extraction, I and U immediates
//   alu operation select for add, sub, and, or, xor, addi, lui
//   ebreak detection, unknown encodings retire as no-ops
`timescale 1ns/1ps

module int_decoder (
    input  pipe_pkg::id_payload_t id_i,
    output pipe_pkg::reg_idx_t    rs1_o,
    output pipe_pkg::reg_idx_t    rs2_o,
    output logic                  use_rs1_o,
    output logic                  use_rs2_o,
    input  pipe_pkg::xlen_t       rs1_val_i,
    input  pipe_pkg::xlen_t       rs2_val_i,
    output pipe_pkg::ex_payload_t ex_o
);
    import pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      imm_i_type;
    xlen_t      imm_u_type;
    logic       writes_rd;

    assign opcode = id_i.instr[6:0];
    assign rd     = id_i.instr[11:7];
    assign funct3 = id_i.instr[14:12];
    assign rs1_o  = id_i.instr[19:15];
    assign rs2_o  = id_i.instr[24:20];
    assign funct7 = id_i.instr[31:25];

    assign imm_i_type = {{52{id_i.instr[31]}}, id_i.instr[31:20]};
    assign imm_u_type = {{32{id_i.instr[31]}}, id_i.instr[31:12], 12'b0};

    always_comb begin
        writes_rd = 1'b0;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;

        ex_o         = '0;
        ex_o.pc      = id_i.pc;
        ex_o.rd      = rd;
        ex_o.rs1_val = rs1_val_i;
        ex_o.rs2_val = rs2_val_i;
        ex_o.alu_op  = ALU_ADD;

        case (opcode)
            OPC_OP: begin
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ex_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ex_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: ex_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: ex_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: ex_o.alu_op = ALU_AND;
                    default: begin
                        // shifts and compares are not supported
                        use_rs1_o = 1'b0;
                        use_rs2_o = 1'b0;
                        writes_rd = 1'b0;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    use_rs1_o    = 1'b1;
                    writes_rd    = 1'b1;
                    ex_o.use_imm = 1'b1;
                    ex_o.imm     = imm_i_type;
                end
            end
            OPC_LUI: begin
                writes_rd    = 1'b1;
                ex_o.use_imm = 1'b1;
                ex_o.imm     = imm_u_type;
                ex_o.alu_op  = ALU_PASS_B;
            end
            OPC_SYSTEM: begin
                ex_o.ebreak = (id_i.instr == INSTR_EBREAK);
            end
            default: ;
        endcase

        // x0 is never written
        ex_o.wen = writes_rd && (rd != '0);
    end

endmodule

//--- hdl/pipe_stage_reg.sv
// pipeline stage register
//   valid bit plus a payload of any packed type
//   flush clears both, enable loads, otherwise hold
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     flush_i,
    input  logic     enable_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (enable_i) begin
            valid_q <= valid_i;
            data_q  <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

//--- hdl/pipe_pkg.sv
// shared definitions for the integer pipeline
//   data, instruction and register index widths
//   major opcodes and the ebreak encoding
//   alu operation enum
//   payload structs of the decode, execute and writeback stage registers
package pipe_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int NUM_REGS = 32;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam instr_t INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // fetched instruction waiting in decode
    typedef struct packed {
        xlen_t  pc;
        instr_t instr;
    } id_payload_t;

    // decoded instruction with its operands
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     wen;
        logic     ebreak;
    } ex_payload_t;

    // result on its way to the register file
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    wdata;
        logic     wen;
        logic     ebreak;
    } wb_payload_t;

endpackage
